/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := mcast_fork_tb
FILELIST  := filelist.f
LOG       := sim.log
RUNFLAGS  := +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
hw/mcast_pkg.sv
hw/flow_fifo.sv
hw/fork_select_multihot.sv
hw/wb_push_port.sv
hw/mcast_fork_top.sv
verification/mcast_fork_chk.sv
verification/mcast_fork_tb.sv

/* hw/flow_fifo.sv */
`default_nettype none

module flow_fifo #(
  parameter int Width = 32,
  parameter int Depth = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [Width-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [Width-1:0] out_data
);

  // Pointer width, at least one bit for a single-entry queue
  localparam int PTR_W = (Depth > 1) ? $clog2(Depth) : 1;
  // Count must reach Depth itself
  localparam int CNT_W = $clog2(Depth + 1);

  logic [Width-1:0] mem [Depth];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_next;
  logic [CNT_W-1:0] count;
  // Entries still stored after this cycle's pop, before this cycle's push
  logic [CNT_W-1:0] held;
  logic push;
  logic pop;

  // Circular increment, wraps at Depth so non power of two depths work
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // --------------------------------------------------------------------------
  // Handshakes
  // --------------------------------------------------------------------------

  // Not full
  assign in_ready  = (count != CNT_W'(Depth));
  // Count is registered, so valid rises the cycle after a write
  assign out_valid = (count != '0);
  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  assign held = pop ? count - 1'b1 : count;
  assign rd_ptr_next = pop ? ptr_inc(rd_ptr) : rd_ptr;

  // --------------------------------------------------------------------------
  // Pointers and count
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      rd_ptr <= rd_ptr_next;

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Storage and registered head
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end

    // Head comes straight from the input when storage drains to empty,
    // else from the next read slot. Without a pop the head slot is
    // reloaded with itself, which keeps the data stable under stall
    if (held == '0) begin
      out_data <= in_data;
    end else begin
      out_data <= mem[rd_ptr_next];
    end
  end

endmodule

`default_nettype wire

/* hw/fork_select_multihot.sv */
`default_nettype none

module fork_select_multihot (
  input  logic                  push_valid,
  output logic                  push_ready,
  // Destination set, only meaningful while push_valid is high
  input  mcast_pkg::flow_mask_t push_select_multihot,
  // Per flow, the queue below can take an item
  input  mcast_pkg::flow_mask_t pop_ready,
  // May fall without a pop, whenever a peer flow loses its ready
  output mcast_pkg::flow_mask_t pop_valid_unstable
);

  // Flows that are selected but cannot take the item
  mcast_pkg::flow_mask_t blocked;

  // --------------------------------------------------------------------------
  // All-or-none rule
  // --------------------------------------------------------------------------

  assign blocked = push_select_multihot & ~pop_ready;

  // Upstream advances only when no selected flow is blocked;
  // unselected flows play no part in flow control
  assign push_ready = (blocked == '0);

  // A flow's valid ignores its own ready, so there is no
  // combinational loop through the queue below it
  always_comb begin
    for (int i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin
      pop_valid_unstable[i] = push_valid && push_select_multihot[i] &&
                              ((blocked & ~(mcast_pkg::flow_mask_t'(1) << i)) == '0);
    end
  end

endmodule

`default_nettype wire

/* hw/mcast_fork_top.sv */
`default_nettype none

module mcast_fork_top (
  input  logic                                            clk,
  input  logic                                            rst,
  // Host port, Wishbone classic
  input  logic                                            wb_cyc,
  input  logic                                            wb_stb,
  input  logic                                            wb_we,
  input  mcast_pkg::wb_addr_t                             wb_adr,
  input  mcast_pkg::payload_t                             wb_dat_w,
  output mcast_pkg::payload_t                             wb_dat_r,
  output logic                                            wb_ack,
  // Output streams, one ready/valid port per flow
  input  mcast_pkg::flow_mask_t                           out_ready,
  output mcast_pkg::flow_mask_t                           out_valid,
  output mcast_pkg::payload_t [mcast_pkg::NUM_FLOWS-1:0] out_data
);

  // Port to input queue
  logic                  push_valid;
  logic                  push_ready;
  mcast_pkg::push_item_t push_item;

  // Input queue head to fork
  logic                  q_valid;
  logic                  q_ready;
  mcast_pkg::push_item_t q_item;

  // Fork to output queues
  mcast_pkg::flow_mask_t pop_valid;
  mcast_pkg::flow_mask_t pop_ready;

  // --------------------------------------------------------------------------
  // Host side
  // --------------------------------------------------------------------------

  wb_push_port u_port (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .push_valid (push_valid),
    .push_item  (push_item),
    .push_ready (push_ready)
  );

  // Mask and payload travel together through the input queue
  flow_fifo #(
    .Width ($bits(mcast_pkg::push_item_t)),
    .Depth (mcast_pkg::IN_DEPTH)
  ) u_in_q (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (push_valid),
    .in_ready  (push_ready),
    .in_data   (push_item),
    .out_valid (q_valid),
    .out_ready (q_ready),
    .out_data  (q_item)
  );

  // --------------------------------------------------------------------------
  // Fork, control only
  // --------------------------------------------------------------------------

  fork_select_multihot u_fork (
    .push_valid           (q_valid),
    .push_ready           (q_ready),
    .push_select_multihot (q_item.mask),
    .pop_ready            (pop_ready),
    .pop_valid_unstable   (pop_valid)
  );

  // --------------------------------------------------------------------------
  // Output queues
  // --------------------------------------------------------------------------

  // Every queue sees the same payload; only the selected ones get a valid
  for (genvar i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin : gen_out
    flow_fifo #(
      .Width (mcast_pkg::PAYLOAD_W),
      .Depth (mcast_pkg::OUT_DEPTH)
    ) u_out_q (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (pop_valid[i]),
      .in_ready  (pop_ready[i]),
      .in_data   (q_item.payload),
      .out_valid (out_valid[i]),
      .out_ready (out_ready[i]),
      .out_data  (out_data[i])
    );
  end

endmodule

`default_nettype wire

/* hw/mcast_pkg.sv */
`default_nettype none

package mcast_pkg;

  // --------------------------------------------------------------------------
  // Sizing
  // --------------------------------------------------------------------------

  // Output flows served by the fork
  localparam int NUM_FLOWS = 4;
  // Payload and register data width
  localparam int PAYLOAD_W = 32;
  // Wishbone register select width
  localparam int ADDR_W = 2;
  // Width of each status counter, two of them fill one register
  localparam int STAT_W = 16;

  // Input queue depth, kept shallow so back-pressure reaches the bus quickly
  localparam int IN_DEPTH = 2;
  // Depth of every per-flow output queue
  localparam int OUT_DEPTH = 4;

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------

  // One data word on the bus or on a stream
  typedef logic [PAYLOAD_W-1:0] payload_t;
  // One bit per output flow
  typedef logic [NUM_FLOWS-1:0] flow_mask_t;
  // Register select on the host port
  typedef logic [ADDR_W-1:0] wb_addr_t;
  // Saturating event counter
  typedef logic [STAT_W-1:0] stat_count_t;

  // --------------------------------------------------------------------------
  // Register map
  // --------------------------------------------------------------------------

  // Payload staging register, write only
  localparam wb_addr_t REG_PAYLOAD = 2'd0;
  // Writing a mask here launches the staged payload
  localparam wb_addr_t REG_DISPATCH = 2'd1;
  // Drop count in the upper half, dispatch count in the lower half
  localparam wb_addr_t REG_STATUS = 2'd2;

  // --------------------------------------------------------------------------
  // Queued item
  // --------------------------------------------------------------------------

  // Mask sits in the upper bits, payload below it
  typedef struct packed {
    flow_mask_t mask;
    payload_t   payload;
  } push_item_t;

endpackage

`default_nettype wire

/* hw/wb_push_port.sv */
`default_nettype none

module wb_push_port (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  mcast_pkg::wb_addr_t   wb_adr,
  input  mcast_pkg::payload_t   wb_dat_w,
  output mcast_pkg::payload_t   wb_dat_r,
  output logic                  wb_ack,
  output logic                  push_valid,
  output mcast_pkg::push_item_t push_item,
  input  logic                  push_ready
);

  // New access, not yet answered and no push pending
  logic req;
  // Dispatch write seen this cycle
  logic is_dispatch;
  // Low bits of the write data taken as the destination mask
  mcast_pkg::flow_mask_t mask_w;
  // Dispatch with at least one flow selected
  logic disp_push;
  // Dispatch with no flow selected, answered and counted only
  logic disp_drop;
  // Pending item accepted by the input queue
  logic push_taken;
  // Registered ack for every access except a live dispatch
  logic ack_q;
  // Staged payload
  mcast_pkg::payload_t payload_q;
  mcast_pkg::stat_count_t dispatch_count;
  mcast_pkg::stat_count_t drop_count;

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------

  // The ack cycle and the pending push both block a second decode of the
  // same strobe
  assign req = wb_cyc && wb_stb && !wb_ack && !push_valid;
  assign is_dispatch = req && wb_we && (wb_adr == mcast_pkg::REG_DISPATCH);
  assign mask_w = wb_dat_w[mcast_pkg::NUM_FLOWS-1:0];
  assign disp_push = is_dispatch && (mask_w != '0);
  assign disp_drop = is_dispatch && (mask_w == '0);
  assign push_taken = push_valid && push_ready;

  // Dispatch ack comes in the cycle the queue takes the item,
  // all others one cycle after the request
  assign wb_ack = ack_q || push_taken;

  // --------------------------------------------------------------------------
  // Control state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q          <= 1'b0;
      push_valid     <= 1'b0;
      dispatch_count <= '0;
      drop_count     <= '0;
    end else begin
      ack_q <= req && !disp_push;

      // Hold valid until the input queue accepts
      if (disp_push) begin
        push_valid <= 1'b1;
      end else if (push_taken) begin
        push_valid <= 1'b0;
      end

      // Both counters stick at their maximum
      if (push_taken && (dispatch_count != '1)) begin
        dispatch_count <= dispatch_count + 1'b1;
      end
      if (disp_drop && (drop_count != '1)) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Data registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req && wb_we && (wb_adr == mcast_pkg::REG_PAYLOAD)) begin
      payload_q <= wb_dat_w;
    end

    // Item is captured with the payload staged before the dispatch write
    if (disp_push) begin
      push_item.mask    <= mask_w;
      push_item.payload <= payload_q;
    end

    // Only the status register reads back; other reads return zero
    if (req && !wb_we) begin
      if (wb_adr == mcast_pkg::REG_STATUS) begin
        wb_dat_r <= {drop_count, dispatch_count};
      end else begin
        wb_dat_r <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/mcast_fork_chk.sv */
`default_nettype none

module mcast_fork_chk (
  input logic                                           clk,
  input logic                                           rst,
  input logic                                           wb_cyc,
  input logic                                           wb_stb,
  input logic                                           wb_ack,
  input mcast_pkg::flow_mask_t                          out_valid,
  input mcast_pkg::flow_mask_t                          out_ready,
  input mcast_pkg::payload_t [mcast_pkg::NUM_FLOWS-1:0] out_data
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions so far, summed into the testbench verdict
  int fail_count = 0;

  // --------------------------------------------------------------------------
  // Host port
  // --------------------------------------------------------------------------

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> (wb_cyc && wb_stb))
  else begin
    fail_count++;
    $error("wb_ack raised outside a bus cycle");
  end

  // Classic cycles end with a single ack pulse
  a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack)
  else begin
    fail_count++;
    $error("wb_ack high for two cycles in a row");
  end

  // --------------------------------------------------------------------------
  // Output streams
  // --------------------------------------------------------------------------

  a_reset_quiet: assert property (@(posedge clk)
    rst |=> ((out_valid == '0) && !wb_ack))
  else begin
    fail_count++;
    $error("output valid or ack seen right after reset");
  end

  for (genvar i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin : gen_flow
    // Stalled beat keeps valid and data until taken
    a_hold: assert property (@(posedge clk) disable iff (rst)
      (out_valid[i] && !out_ready[i]) |=> (out_valid[i] && $stable(out_data[i])))
    else begin
      fail_count++;
      $error("flow %0d lost valid or changed data while stalled", i);
    end
  end

endmodule

bind mcast_fork_top mcast_fork_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data)
);

`default_nettype wire

/* verification/mcast_fork_tb.sv */
`default_nettype none

module mcast_fork_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {SINK_ON, SINK_OFF, SINK_RANDOM} sink_mode_t;

  // Limit set by the random test of 200 items at about 7 cycles each plus a margin
  localparam int MAX_CYCLES = 3000;
  localparam int ACK_LIMIT  = 100;

  logic                                           clk = 1'b0;
  logic                                           rst;
  logic                                           wb_cyc;
  logic                                           wb_stb;
  logic                                           wb_we;
  mcast_pkg::wb_addr_t                            wb_adr;
  mcast_pkg::payload_t                            wb_dat_w;
  mcast_pkg::payload_t                            wb_dat_r;
  logic                                           wb_ack;
  mcast_pkg::flow_mask_t                          out_ready;
  mcast_pkg::flow_mask_t                          out_valid;
  mcast_pkg::payload_t [mcast_pkg::NUM_FLOWS-1:0] out_data;

  // Reference model filled by the monitor
  mcast_pkg::payload_t exp_q [mcast_pkg::NUM_FLOWS][$];
  mcast_pkg::payload_t staged = '0;
  int beats [mcast_pkg::NUM_FLOWS] = '{default: 0};
  int disp_exp = 0;
  int drop_exp = 0;
  int beat_errors = 0;

  // Sequence state
  sink_mode_t ready_mode [mcast_pkg::NUM_FLOWS];
  int base [mcast_pkg::NUM_FLOWS];
  int seed = 32'h0643c663;
  int check_errors = 0;
  int errs_at_start = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycles = 0;

  mcast_fork_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, tests did not finish", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  function automatic int total_errors();
    return check_errors + beat_errors + u_dut.u_chk.fail_count;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAIL at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
      check_errors++;
    end
  endtask

  // Accepted beat against the head of that flow's reference queue
  task automatic check_beat(input int flow);
    mcast_pkg::payload_t expected;
    if (exp_q[flow].size() == 0) begin
      $display("Unexpected beat at %0t on flow %0d, nothing was sent there", $time, flow);
      beat_errors++;
    end else begin
      expected = exp_q[flow].pop_front();
      assert (out_data[flow] === expected) else begin
        $display("FAIL at %0t: out_data[%0d] expected %0h actual %0h",
                 $time, flow, expected, out_data[flow]);
        beat_errors++;
      end
      beats[flow]++;
    end
  endtask

  // Ready pattern per flow chosen on each rising edge and driven 5 ns later
  task automatic drive_sinks();
    logic [31:0] r;
    mcast_pkg::flow_mask_t next_ready;
    forever begin
      @(posedge clk);
      for (int i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin
        r = $random(seed);
        case (ready_mode[i])
          SINK_ON:  next_ready[i] = 1'b1;
          SINK_OFF: next_ready[i] = 1'b0;
          default:  next_ready[i] = r[0];
        endcase
      end
      #5;
      out_ready = next_ready;
    end
  endtask

  // One classic cycle held until the ack is sampled
  task automatic wb_access(input logic we, input mcast_pkg::wb_addr_t adr,
                           input mcast_pkg::payload_t wdata,
                           output mcast_pkg::payload_t rdata);
    int waited = 0;
    @(posedge clk);
    #5;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do begin
      @(negedge clk);
      waited++;
    end while (!wb_ack && (waited < ACK_LIMIT));
    if (!wb_ack) begin
      $display("No wb_ack within %0d cycles at address %0d", ACK_LIMIT, adr);
      check_errors++;
    end
    rdata = wb_dat_r;
    @(posedge clk);
    #5;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic dispatch_item(input mcast_pkg::payload_t payload,
                               input mcast_pkg::flow_mask_t mask);
    mcast_pkg::payload_t rd;
    wb_access(1'b1, mcast_pkg::REG_PAYLOAD, payload, rd);
    wb_access(1'b1, mcast_pkg::REG_DISPATCH, 32'(mask), rd);
  endtask

  // Until every reference queue is empty and no beat is pending
  task automatic wait_drain(input int limit);
    int waited = 0;
    int pending;
    do begin
      @(negedge clk);
      waited++;
      pending = 0;
      for (int i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin
        pending += exp_q[i].size();
      end
    end while (((pending != 0) || (out_valid != '0)) && (waited < limit));
    if ((pending != 0) || (out_valid != '0)) begin
      $display("Flows did not drain in %0d cycles, %0d items missing", limit, pending);
      check_errors++;
    end
  endtask

  // Expect n beats since start_test on each flow in the mask and none elsewhere
  task automatic expect_beats(input mcast_pkg::flow_mask_t mask, input int n);
    for (int i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin
      expect_equal($sformatf("beats on flow %0d", i), mask[i] ? n : 0, beats[i] - base[i]);
    end
  endtask

  task automatic start_test();
    errs_at_start = total_errors();
    base = beats;
  endtask

  task automatic report_test(input string name);
    int errs = total_errors() - errs_at_start;
    if (errs == 0) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errs);
    end
  endtask

  // --------------------------------------------------------------------------
  // Monitor sampled mid-cycle where everything has settled
  // --------------------------------------------------------------------------

  always @(negedge clk) begin
    if (!rst) begin
      if (wb_ack && wb_we && (wb_adr == mcast_pkg::REG_PAYLOAD)) begin
        staged = wb_dat_w;
      end
      // Acked dispatch copies the staged payload to each selected flow
      if (wb_ack && wb_we && (wb_adr == mcast_pkg::REG_DISPATCH)) begin
        if (wb_dat_w[mcast_pkg::NUM_FLOWS-1:0] == '0) begin
          drop_exp++;
        end else begin
          disp_exp++;
          for (int i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin
            if (wb_dat_w[i]) begin
              exp_q[i].push_back(staged);
            end
          end
        end
      end
      for (int i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin
        if (out_valid[i] && out_ready[i]) begin
          check_beat(i);
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    mcast_pkg::payload_t status;
    mcast_pkg::payload_t data;
    logic [31:0] r;
    rst       = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    out_ready = '1;
    for (int i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin
      ready_mode[i] = SINK_ON;
    end
    fork
      drive_sinks();
    join_none
    repeat (8) @(posedge clk);
    #5;
    rst = 1'b0;

    start_test();
    dispatch_item(32'hc0de_0001, 4'b0100);
    wait_drain(50);
    expect_beats(4'b0100, 1);
    report_test("single flow");

    start_test();
    for (int n = 0; n < 6; n++) begin
      data = $random(seed);
      dispatch_item(data, 4'b1011);
    end
    wait_drain(50);
    expect_beats(4'b1011, 6);
    report_test("multihot burst");

    // Flow 0 stalled so its queue fills first and then the input queue and the bus
    start_test();
    ready_mode[0] = SINK_OFF;
    for (int n = 0; n < mcast_pkg::OUT_DEPTH + mcast_pkg::IN_DEPTH; n++) begin
      dispatch_item(32'h3000_0000 + n, 4'b0111);
    end
    wb_access(1'b1, mcast_pkg::REG_PAYLOAD, 32'h3000_00ff, data);
    fork
      wb_access(1'b1, mcast_pkg::REG_DISPATCH, 32'h7, data);
      begin
        repeat (10) @(negedge clk);
        expect_equal("wb_ack under stall", 0, 32'(wb_ack));
        expect_equal("wb_stb under stall", 1, 32'(wb_stb));
        expect_beats(4'b0110, mcast_pkg::OUT_DEPTH);
        ready_mode[0] = SINK_ON;
      end
    join
    wait_drain(100);
    expect_beats(4'b0111, mcast_pkg::OUT_DEPTH + mcast_pkg::IN_DEPTH + 1);
    report_test("back-pressure");

    start_test();
    dispatch_item(32'h4444_0000, 4'b0000);
    repeat (6) @(negedge clk);
    expect_beats(4'b0000, 0);
    wb_access(1'b0, mcast_pkg::REG_STATUS, '0, status);
    expect_equal("drop_count", 1, 32'(status[31:16]));
    report_test("zero mask");

    start_test();
    wb_access(1'b0, mcast_pkg::REG_STATUS, '0, status);
    expect_equal("dispatch_count", disp_exp, 32'(status[15:0]));
    report_test("dispatch count");

    start_test();
    for (int i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin
      ready_mode[i] = SINK_RANDOM;
    end
    for (int n = 0; n < 200; n++) begin
      r    = $random(seed);
      data = $random(seed);
      dispatch_item(data, r[3:0]);
    end
    for (int i = 0; i < mcast_pkg::NUM_FLOWS; i++) begin
      ready_mode[i] = SINK_ON;
    end
    wait_drain(200);
    wb_access(1'b0, mcast_pkg::REG_STATUS, '0, status);
    expect_equal("dispatch_count", disp_exp, 32'(status[15:0]));
    expect_equal("drop_count", drop_exp, 32'(status[31:16]));
    report_test("random traffic");

    $display("Tests passed %0d, failed %0d, errors %0d",
             tests_passed, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
